// File: rtl/switch_info_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared sizes, region code and PU command types
// for the switch-info lookup table.
// ~~~~~~~~~~~~~~~~~~~~

package switch_info_pkg;

	// Cluster size.
	localparam int NUM_PU  = 4;
	localparam int PU_ID_W = 2;    // Index of one PU.

	// Data and host bus widths.
	localparam int DATA_W = 32;    // Table word and host data.
	localparam int PIO_W  = 32;    // Host address bus.

	// Table geometry.
	localparam int FID_W   = 2;    // Flow id.
	localparam int ENTRY_W = 6;    // Word within one flow's block.
	localparam int DEPTH_W = FID_W + ENTRY_W;    // 256 words.

	// PU address layout.
	localparam int ADDR_W   = 16;
	localparam int REGION_W = 4;   // Top bits name the target region.

	localparam logic [REGION_W-1:0] REGION_SWITCH_INFO = 4'h5;

	// Reads in flight between grant and table ack.
	localparam int TAG_DEPTH = 2;

	// Decoded view of a PU address.
	typedef struct packed {
		logic [REGION_W-1:0]                region;  // Target memory region.
		logic [ADDR_W-REGION_W-ENTRY_W-1:0] rsvd;    // Not decoded here.
		logic [ENTRY_W-1:0]                 entry;   // Word within the flow block.
	} pu_addr_fields_t;

	// The same address word, raw or split into its fields.
	typedef union packed {
		logic [ADDR_W-1:0] raw;
		pu_addr_fields_t   fields;
	} pu_addr_u;

	// One PU command.
	typedef struct packed {
		logic [FID_W-1:0] fid;     // Flow id selects a 64-word block.
		pu_addr_u         addr;
	} io_cmd_t;

endpackage

// File: rtl/rr_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~
// Round-robin arbiter, one grant per cycle.
// ~~~~~~~~~~~~~~~~~~~~

module rr_arbiter (
	input  logic                                clk,
	input  logic                                rst_n,

	input  logic [switch_info_pkg::NUM_PU-1:0]  req,

	output logic                                gnt,
	output logic [switch_info_pkg::PU_ID_W-1:0] sel,
	output logic [switch_info_pkg::NUM_PU-1:0]  ack
);

	logic [switch_info_pkg::PU_ID_W-1:0] ptr;    // First PU to look at.

	// Search starts at the pointer and wraps around the cluster.
	always_comb begin : pick
		logic [switch_info_pkg::PU_ID_W:0]   k;
		logic [switch_info_pkg::PU_ID_W-1:0] cand;
		logic                                found;

		found = 1'b0;
		sel   = ptr;
		for (k = '0; k < switch_info_pkg::NUM_PU; k = k + 1'b1) begin
			cand = ptr + k[switch_info_pkg::PU_ID_W-1:0];    // Wraps naturally.
			if (!found && req[cand]) begin
				found = 1'b1;
				sel   = cand;
			end
		end
		gnt = found;
	end

	// One-hot form of the grant.
	always_comb begin
		ack      = '0;
		ack[sel] = gnt;
	end

	// Pointer moves just past the winner.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (gnt) begin
			ptr <= sel + {{(switch_info_pkg::PU_ID_W-1){1'b0}}, 1'b1};
		end
	end

endmodule

// File: rtl/tag_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~
// In-order FIFO of PU ids for reads in flight.
// ~~~~~~~~~~~~~~~~~~~~

module tag_fifo #(
	parameter int DEPTH = switch_info_pkg::TAG_DEPTH    // Power of two.
) (
	input  logic                                clk,
	input  logic                                rst_n,

	input  logic                                push,
	input  logic [switch_info_pkg::PU_ID_W-1:0] din,

	input  logic                                pop,
	output logic [switch_info_pkg::PU_ID_W-1:0] head_id,
	output logic                                empty
);

	logic [switch_info_pkg::PU_ID_W-1:0] mem [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0]   count;    // Entries held.
	logic                     do_pop;

	assign empty   = (count == '0);
	assign do_pop  = pop && !empty;    // Ignore a pop with nothing stored.
	assign head_id = mem[rd_ptr];      // Oldest entry, shown ahead of the pop.

	// Storage.
	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	// Pointers and count.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // Idle, or push and pop together.
			endcase
		end
	end

endmodule

// File: rtl/pio_mem_bram.sv
// ~~~~~~~~~~~~~~~~~~~~
// Dual-port table with a host register port
// and an application read port.
// ~~~~~~~~~~~~~~~~~~~~

module pio_mem_bram (
	input  logic                                clk,
	input  logic                                rst_n,

	// Host register port.
	input  logic                                reg_sel,
	input  logic                                reg_rd,
	input  logic                                reg_wr,
	input  logic [switch_info_pkg::PIO_W-1:0]   reg_addr,
	input  logic [switch_info_pkg::DATA_W-1:0]  reg_din,
	output logic                                mem_ack,
	output logic [switch_info_pkg::DATA_W-1:0]  mem_rdata,

	// Application read port.
	input  logic                                app_rd,
	input  logic [switch_info_pkg::DEPTH_W-1:0] app_raddr,
	output logic                                app_ack,
	output logic [switch_info_pkg::DATA_W-1:0]  app_rdata
);

	logic [switch_info_pkg::DATA_W-1:0] mem [2**switch_info_pkg::DEPTH_W];

	logic [switch_info_pkg::DEPTH_W-1:0] host_idx;
	logic                                host_req;
	logic                                host_rd;
	logic                                host_wr;

	assign host_idx = reg_addr[switch_info_pkg::DEPTH_W-1:0];    // Low bits index the table.
	assign host_req = reg_sel && (reg_rd || reg_wr);
	assign host_rd  = reg_sel && reg_rd;
	assign host_wr  = reg_sel && reg_wr;

	// Host writes.
	always_ff @(posedge clk) begin
		if (host_wr) begin
			mem[host_idx] <= reg_din;
		end
	end

	// Host ack and read data zeroed outside the ack.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_ack   <= 1'b0;
			mem_rdata <= '0;
		end else begin
			mem_ack <= host_req;
			if (host_rd) begin
				mem_rdata <= mem[host_idx];
			end else begin
				mem_rdata <= '0;
			end
		end
	end

	// Application read with one cycle of latency.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			app_ack <= 1'b0;
		end else begin
			app_ack <= app_rd;
		end
	end

	// Read word only matters while app_ack is high.
	always_ff @(posedge clk) begin
		if (app_rd) begin
			app_rdata <= mem[app_raddr];
		end
	end

endmodule

// File: rtl/pu_switch_info_mem.sv
// ~~~~~~~~~~~~~~~~~~~~
// Shared switch-info lookup for four PUs, with
// request capture, arbitration and ack steering.
// ~~~~~~~~~~~~~~~~~~~~

module pu_switch_info_mem (
	input  logic                                clk,
	input  logic                                rst_n,

	// PU side.
	input  logic [switch_info_pkg::NUM_PU-1:0]  io_req,
	input  switch_info_pkg::io_cmd_t            io_cmd [switch_info_pkg::NUM_PU],
	output logic [switch_info_pkg::NUM_PU-1:0]  io_ack,
	output logic [switch_info_pkg::DATA_W-1:0]  io_ack_data [switch_info_pkg::NUM_PU],

	// Host register port.
	input  logic                                reg_sel,
	input  logic                                reg_rd,
	input  logic                                reg_wr,
	input  logic [switch_info_pkg::PIO_W-1:0]   reg_addr,
	input  logic [switch_info_pkg::DATA_W-1:0]  reg_din,
	output logic                                reg_ack,
	output logic [switch_info_pkg::DATA_W-1:0]  reg_rdata
);

	// Captured commands, one per PU.
	logic [switch_info_pkg::FID_W-1:0] fid_q  [switch_info_pkg::NUM_PU];
	switch_info_pkg::pu_addr_u         addr_q [switch_info_pkg::NUM_PU];

	logic [switch_info_pkg::NUM_PU-1:0]  hit;        // Request for this table.
	logic [switch_info_pkg::NUM_PU-1:0]  pending;    // Waiting for a grant.

	// Arbiter.
	logic                                arb_gnt;
	logic [switch_info_pkg::PU_ID_W-1:0] arb_sel;
	logic [switch_info_pkg::NUM_PU-1:0]  arb_ack;

	// Table application port.
	logic [switch_info_pkg::DEPTH_W-1:0] app_raddr;
	logic                                app_ack;
	logic [switch_info_pkg::DATA_W-1:0]  app_rdata;

	// Owner of the returned word.
	logic [switch_info_pkg::PU_ID_W-1:0] head_id;
	logic                                tag_empty;
	logic [switch_info_pkg::NUM_PU-1:0]  owner_oh;

	// Region decode. Requests for other regions are dropped.
	always_comb begin
		for (int i = 0; i < switch_info_pkg::NUM_PU; i++) begin
			hit[i] = io_req[i] &&
				(io_cmd[i].addr.fields.region == switch_info_pkg::REGION_SWITCH_INFO);
		end
	end

	// Command capture on an accepted request.
	always_ff @(posedge clk) begin
		for (int i = 0; i < switch_info_pkg::NUM_PU; i++) begin
			if (hit[i]) begin
				fid_q[i]      <= io_cmd[i].fid;
				addr_q[i].raw <= io_cmd[i].addr.raw;
			end
		end
	end

	// Set on accept, clear on grant.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~arb_ack) | hit;
		end
	end

	rr_arbiter u_rr_arbiter (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (pending),
		.gnt   (arb_gnt),
		.sel   (arb_sel),
		.ack   (arb_ack)
	);

	// Flow id picks the block, entry the word inside it.
	assign app_raddr = {fid_q[arb_sel], addr_q[arb_sel].fields.entry};

	tag_fifo #(
		.DEPTH (switch_info_pkg::TAG_DEPTH)
	) u_tag_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.push    (arb_gnt),
		.din     (arb_sel),
		.pop     (app_ack),
		.head_id (head_id),
		.empty   (tag_empty)
	);

	pio_mem_bram u_pio_mem_bram (
		.clk       (clk),
		.rst_n     (rst_n),
		.reg_sel   (reg_sel),
		.reg_rd    (reg_rd),
		.reg_wr    (reg_wr),
		.reg_addr  (reg_addr),
		.reg_din   (reg_din),
		.mem_ack   (reg_ack),
		.mem_rdata (reg_rdata),
		.app_rd    (arb_gnt),
		.app_raddr (app_raddr),
		.app_ack   (app_ack),
		.app_rdata (app_rdata)
	);

	// Table ack steered to the oldest tag.
	always_comb begin
		owner_oh          = '0;
		owner_oh[head_id] = app_ack && !tag_empty;
	end

	// Registered acknowledge with data zero outside the pulse.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			io_ack <= '0;
			for (int i = 0; i < switch_info_pkg::NUM_PU; i++) begin
				io_ack_data[i] <= '0;
			end
		end else begin
			io_ack <= owner_oh;
			for (int i = 0; i < switch_info_pkg::NUM_PU; i++) begin
				io_ack_data[i] <= owner_oh[i] ? app_rdata : '0;
			end
		end
	end

endmodule

// File: tb/tb_pu_switch_info_mem.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench for the switch-info lookup: clock, reset, shadow
// table, ack monitor, directed tests and timeout.
// ~~~~~~~~~~~~~~~~~~~~

module tb_pu_switch_info_mem;

	timeunit 1ns;
	timeprecision 1ps;

	logic                                clk;
	logic                                rst_n;
	logic [switch_info_pkg::NUM_PU-1:0]  io_req;
	switch_info_pkg::io_cmd_t            io_cmd [switch_info_pkg::NUM_PU];
	logic [switch_info_pkg::NUM_PU-1:0]  io_ack;
	logic [switch_info_pkg::DATA_W-1:0]  io_ack_data [switch_info_pkg::NUM_PU];
	logic                                reg_sel;
	logic                                reg_rd;
	logic                                reg_wr;
	logic [switch_info_pkg::PIO_W-1:0]   reg_addr;
	logic [switch_info_pkg::DATA_W-1:0]  reg_din;
	logic                                reg_ack;
	logic [switch_info_pkg::DATA_W-1:0]  reg_rdata;

	logic [switch_info_pkg::DATA_W-1:0] shadow [2**switch_info_pkg::DEPTH_W];  // Host copy.
	integer      seed;
	int unsigned cyc = 0;    // Edges seen so far.

	// PU scoreboard with one outstanding request per PU.
	int unsigned post_cnt [switch_info_pkg::NUM_PU] = '{default: 0};
	int unsigned done_cnt [switch_info_pkg::NUM_PU] = '{default: 0};
	int unsigned req_cyc  [switch_info_pkg::NUM_PU] = '{default: 0};  // Sampling edge.
	logic [31:0] exp_data [switch_info_pkg::NUM_PU] = '{default: '0};

	// Every acknowledge in arrival order.
	int unsigned ack_pu_q  [$];
	int unsigned ack_cyc_q [$];
	int unsigned ack_lat_q [$];

	pu_switch_info_mem UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.io_req      (io_req),
		.io_cmd      (io_cmd),
		.io_ack      (io_ack),
		.io_ack_data (io_ack_data),
		.reg_sel     (reg_sel),
		.reg_rd      (reg_rd),
		.reg_wr      (reg_wr),
		.reg_addr    (reg_addr),
		.reg_din     (reg_din),
		.reg_ack     (reg_ack),
		.reg_rdata   (reg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_run();
		$display("Errors found");
		$fatal(1, "simulation stopped after an error");
	endtask

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string msg);
		if (actual !== expected) begin
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
			stop_run();
		end
	endtask

	function automatic logic [31:0] next_rand();
		next_rand = $random(seed);
	endfunction

	function automatic logic busy(input int p);
		busy = (post_cnt[p] != done_cnt[p]);
	endfunction

	function automatic logic any_busy();
		any_busy = 1'b0;
		for (int p = 0; p < switch_info_pkg::NUM_PU; p++) begin
			any_busy = any_busy | busy(p);
		end
	endfunction

	// Cycle count and a run limit of 2000 against about 1100 cycles of tests.
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= 2000) begin
			$display("Timeout: the run went past 2000 cycles");
			stop_run();
		end
	end

	// Collects each acknowledge and checks it against the scoreboard.
	always @(posedge clk) begin
		if (rst_n) begin
			for (int p = 0; p < switch_info_pkg::NUM_PU; p++) begin
				if (io_ack[p]) begin
					if (!busy(p)) begin
						$display("PU %0d got an acknowledge it did not request", p);
						stop_run();
					end
					if (cyc - req_cyc[p] < 3 || cyc - req_cyc[p] > 6) begin
						$display("PU %0d acknowledged %0d cycles after its request", p,
							cyc - req_cyc[p]);
						stop_run();
					end
					check(io_ack_data[p], exp_data[p], $sformatf("PU %0d ack data", p));
					ack_pu_q.push_back(p);
					ack_cyc_q.push_back(cyc);
					ack_lat_q.push_back(cyc - req_cyc[p]);
					done_cnt[p] <= done_cnt[p] + 1;
				end else begin
					check(io_ack_data[p], '0, $sformatf("PU %0d data outside ack", p));
					if (busy(p) && cyc - req_cyc[p] > 6) begin
						$display("PU %0d got no acknowledge within six cycles", p);
						stop_run();
					end
				end
			end
		end
	end

	// One host transfer with its ack expected one cycle after the strobe.
	task automatic host_access(input logic wr, input logic [31:0] addr,
			input logic [31:0] wdata);
		logic [7:0] idx;

		idx = addr[7:0];
		@(posedge clk);
		reg_sel  <= 1'b1;
		reg_wr   <= wr;
		reg_rd   <= !wr;
		reg_addr <= addr;
		reg_din  <= wdata;
		if (wr) begin
			shadow[idx] = wdata;
		end
		@(posedge clk);
		reg_sel <= 1'b0;
		reg_rd  <= 1'b0;
		reg_wr  <= 1'b0;
		check(32'(reg_ack), 32'd0, "reg_ack during the strobe");
		check(reg_rdata, '0, "reg_rdata outside ack");
		@(posedge clk);
		check(32'(reg_ack), 32'd1, "reg_ack one cycle after strobe");
		check(reg_rdata, wr ? 32'd0 : shadow[idx], $sformatf("host read of %0d", idx));
	endtask

	// Drives one request pulse bit that the caller clears on the next edge.
	task automatic post_req(input int p, input logic [1:0] fid, input logic [3:0] region,
			input logic [5:0] entry);
		switch_info_pkg::io_cmd_t cmd;
		logic [31:0]              r;

		r = next_rand();
		cmd.fid                = fid;
		cmd.addr.fields.region = region;
		cmd.addr.fields.rsvd   = r[5:0];
		cmd.addr.fields.entry  = entry;
		io_cmd[p] <= cmd;
		io_req[p] <= 1'b1;
		if (region == switch_info_pkg::REGION_SWITCH_INFO) begin
			exp_data[p] <= shadow[int'(fid) * 64 + int'(entry)];
			req_cyc[p]  <= cyc + 1;
			post_cnt[p] <= post_cnt[p] + 1;
		end
	endtask

	task automatic wait_idle();
		int n;

		n = 0;
		while (any_busy()) begin
			@(posedge clk);
			n++;
			if (n > 20) begin
				$display("PU requests still outstanding after 20 cycles");
				stop_run();
			end
		end
	endtask

	task automatic host_fill_readback();
		logic [31:0] r;

		for (int i = 0; i < 256; i++) begin
			r = next_rand();
			host_access(1'b1, {r[31:8], 8'(i)}, next_rand());
		end
		repeat (32) begin
			host_access(1'b0, next_rand(), '0);
		end
	endtask

	task automatic single_lookup(input int p, input logic [1:0] fid, input logic [5:0] entry);
		int n0;

		n0 = ack_pu_q.size();
		@(posedge clk);
		post_req(p, fid, switch_info_pkg::REGION_SWITCH_INFO, entry);
		@(posedge clk);
		io_req <= '0;
		wait_idle();
		check(ack_pu_q.size(), n0 + 1, "single lookup ack count");
		check(ack_pu_q[n0], p, "single lookup owner");
		check(ack_lat_q[n0], 3, "single lookup latency");
	endtask

	// All four PUs at once with grants expected in order from first.
	task automatic burst(input int first);
		int          n0;
		logic [31:0] r;

		n0 = ack_pu_q.size();
		@(posedge clk);
		for (int p = 0; p < switch_info_pkg::NUM_PU; p++) begin
			r = next_rand();
			post_req(p, 2'(p), switch_info_pkg::REGION_SWITCH_INFO, r[5:0]);
		end
		@(posedge clk);
		io_req <= '0;
		wait_idle();
		check(ack_pu_q.size(), n0 + 4, "burst ack count");
		for (int i = 0; i < 4; i++) begin
			check(ack_pu_q[n0+i], (first + i) % 4, "burst grant order");
			check(ack_cyc_q[n0+i], ack_cyc_q[n0] + i, "burst ack cycle");
		end
	endtask

	task automatic region_filter();
		int          n0;
		logic [31:0] r;

		n0 = ack_pu_q.size();
		for (int g = 0; g < 16; g += 4) begin
			@(posedge clk);
			for (int p = 0; p < switch_info_pkg::NUM_PU; p++) begin
				r = next_rand();
				if (4'(g + p) != switch_info_pkg::REGION_SWITCH_INFO) begin
					post_req(p, r[1:0], 4'(g + p), r[7:2]);
				end
			end
			@(posedge clk);
			io_req <= '0;
			repeat (10) @(posedge clk);
		end
		check(ack_pu_q.size(), n0, "acks for other regions");
		single_lookup(2, 2'd1, 6'd63);    // PU 2 last sent region 4'he.
	endtask

	task automatic random_traffic();
		logic [31:0] host_addr [66];
		logic [31:0] r;
		int          n0;
		int          posts;

		n0    = ack_pu_q.size();
		posts = 0;
		for (int i = 0; i < 66; i++) begin
			host_addr[i] = next_rand();
		end
		fork
			begin
				repeat (200) begin
					@(posedge clk);
					io_req <= '0;
					for (int p = 0; p < switch_info_pkg::NUM_PU; p++) begin
						r = next_rand();
						if (!busy(p) && r[1:0] != 2'b00) begin
							post_req(p, r[9:8], switch_info_pkg::REGION_SWITCH_INFO, r[15:10]);
							posts++;
						end
					end
				end
				@(posedge clk);
				io_req <= '0;
			end
			begin
				for (int i = 0; i < 66; i++) begin
					host_access(1'b0, host_addr[i], '0);
				end
			end
		join
		wait_idle();
		check(ack_pu_q.size() - n0, posts, "one ack per random request");
	endtask

	initial begin
		seed     = 32'h79eb;
		rst_n    = 1'b0;
		io_req   = '0;
		reg_sel  = 1'b0;
		reg_rd   = 1'b0;
		reg_wr   = 1'b0;
		reg_addr = '0;
		reg_din  = '0;
		for (int p = 0; p < switch_info_pkg::NUM_PU; p++) begin
			io_cmd[p] = '0;
		end
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		host_fill_readback();
		burst(0);                         // Pointer still at PU 0 from reset.
		single_lookup(3, 2'd2, 6'd37);
		single_lookup(1, 2'd0, 6'd5);     // PU 1 wins last.
		burst(2);
		region_filter();
		random_traffic();

		repeat (5) @(posedge clk);
		$display("No errors");
		$finish;
	end

endmodule

// File: src.f
rtl/switch_info_pkg.sv
rtl/rr_arbiter.sv
rtl/tag_fifo.sv
rtl/pio_mem_bram.sv
rtl/pu_switch_info_mem.sv
tb/tb_pu_switch_info_mem.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f src.f \
	--top-module tb_pu_switch_info_mem -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
